/* rtl/mrr_settings.svh */
`ifndef MRR_SETTINGS_SVH
`define MRR_SETTINGS_SVH

// energy sample width from the front end
`define SAMPLE_WIDTH 12

// receive timing geometry
`define SAMPLES_PER_CHIP 4
`define CHIPS_PER_BIT 8

// preamble PN code, first chip in the top bit
`define PN_LEN 15
`define PN_SEQ 15'b000100110101111

// candidate alignments searched, and the bits stored to cover them
`define SEARCH_OFFSETS 16
`define PREAMBLE_BITS 31

// loopback transmit word, on-off keyed
`define TX_BITS 32
`define TX_CHIPS_PER_BIT 4

// busy time after transmit to keep the detector from self-triggering
`define HOLDOFF_CHIPS 64

`endif

/* rtl/mrr_pkg.sv */
`default_nettype none
`include "mrr_settings.svh"

package mrr_pkg;

    // one energy sample
    typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

    // sum over two chips of samples, with headroom
    typedef logic [`SAMPLE_WIDTH+3:0] energy_t;

    // chip position inside a receive bit
    typedef logic [2:0] chip_phase_t;

    // turnaround and holdoff lengths in chips
    typedef logic [15:0] chip_cnt_t;

    typedef logic [3:0] pn_offset_t;

    // matching chips out of PN_LEN
    typedef logic [3:0] pn_score_t;

    typedef enum logic [2:0] {
        READY,
        RX,
        RX_DRAIN,
        TURNAROUND,
        TX,
        HOLDOFF
    } ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/chip_if.sv */
`timescale 1ns/1ps
`default_nettype none

// sample stream plus chip timing, shared by the receive stages
interface chip_if;

    logic                 sample_valid;
    mrr_pkg::sample_t     sample;
    // high on the last valid sample of a chip
    logic                 chip_end;
    mrr_pkg::chip_phase_t chip_phase;

    modport timer (
        output sample_valid,
        output sample,
        output chip_end,
        output chip_phase
    );

    modport slicer (
        input sample_valid,
        input sample,
        input chip_end,
        input chip_phase
    );

    modport ctrl (
        input chip_end
    );

endinterface

`default_nettype wire

/* rtl/chip_timer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mrr_settings.svh"

module chip_timer (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_clear,
    input  wire                   i_sample_valid,
    input  wire mrr_pkg::sample_t i_sample,
    chip_if.timer                 chip
);

    localparam int SAMPLE_CNT_W = $clog2(`SAMPLES_PER_CHIP);
    localparam mrr_pkg::chip_phase_t LAST_CHIP = mrr_pkg::chip_phase_t'(`CHIPS_PER_BIT - 1);

    logic [SAMPLE_CNT_W-1:0] sample_cnt;
    mrr_pkg::chip_phase_t    chip_phase;
    logic                    last_sample;

    assign last_sample = (sample_cnt == SAMPLE_CNT_W'(`SAMPLES_PER_CHIP - 1));

    // stream passes straight through, only the counts are registered
    assign chip.sample_valid = i_sample_valid;
    assign chip.sample       = i_sample;
    assign chip.chip_end     = i_sample_valid && last_sample;
    assign chip.chip_phase   = chip_phase;

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            sample_cnt <= '0;
            chip_phase <= '0;
        end else if (i_sample_valid) begin
            if (last_sample) begin
                sample_cnt <= '0;
                chip_phase <= (chip_phase == LAST_CHIP) ? '0 : chip_phase + 3'd1;
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) chip.chip_end |-> chip.sample_valid)
        else $error("chip_end raised without a sample strobe");

endmodule

`default_nettype wire

/* rtl/bit_slicer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mrr_settings.svh"

module bit_slicer (
    input  wire    clk,
    input  wire    rst,
    input  wire    i_clear,
    chip_if.slicer chip,
    output logic   o_bit_valid,
    output logic   o_bit
);

    localparam mrr_pkg::chip_phase_t LAST_CHIP = mrr_pkg::chip_phase_t'(`CHIPS_PER_BIT - 1);

    mrr_pkg::energy_t zero_energy;
    mrr_pkg::energy_t one_energy;
    mrr_pkg::energy_t sample_ext;

    assign sample_ext = mrr_pkg::energy_t'(chip.sample);

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            zero_energy <= '0;
            one_energy  <= '0;
            o_bit_valid <= 1'b0;
            o_bit       <= 1'b0;
        end else begin
            o_bit_valid <= 1'b0;
            if (chip.sample_valid) begin
                // a zero puts its pulse in chips 3-4, a one in chips 5-6
                case (chip.chip_phase)
                    3'd3, 3'd4: zero_energy <= zero_energy + sample_ext;
                    3'd5, 3'd6: one_energy <= one_energy + sample_ext;
                    default: ;
                endcase
            end
            if (chip.chip_end && chip.chip_phase == LAST_CHIP) begin
                o_bit_valid <= 1'b1;
                // ties go to zero
                o_bit       <= (one_energy > zero_energy);
                zero_energy <= '0;
                one_energy  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/pn_search.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mrr_settings.svh"

module pn_search (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_start,
    input  wire                  i_bit_valid,
    input  wire                  i_bit,
    output logic                 o_done,
    output mrr_pkg::pn_offset_t  o_offset
);

    localparam int FILL_W = $clog2(`PREAMBLE_BITS + 1);
    localparam int IDX_W  = $clog2(`PREAMBLE_BITS);
    localparam int SUB_W  = $clog2(`PN_LEN + 1);
    localparam logic [`PN_LEN-1:0] PN_PATTERN = `PN_SEQ;

    // preamble bit j lands in bits[j] once the fill is complete
    logic [`PREAMBLE_BITS-1:0] bits;
    logic [FILL_W-1:0]         fill_cnt;
    logic                      filling;
    logic                      running;
    mrr_pkg::pn_offset_t       offset;
    mrr_pkg::pn_offset_t       best_offset;
    // chip index within the window, PN_LEN marks the update step
    logic [SUB_W-1:0]          sub;
    mrr_pkg::pn_score_t        score;
    mrr_pkg::pn_score_t        best_score;
    logic [IDX_W-1:0]          rd_idx;
    logic                      pn_bit;
    logic                      better;
    logic                      window_done;
    logic                      last_offset;

    assign rd_idx      = IDX_W'(offset) + IDX_W'(sub);
    assign pn_bit      = PN_PATTERN[SUB_W'(`PN_LEN - 1) - sub];
    assign better      = (score > best_score);
    assign window_done = (sub == SUB_W'(`PN_LEN));
    assign last_offset = (offset == mrr_pkg::pn_offset_t'(`SEARCH_OFFSETS - 1));

    always_ff @(posedge clk) begin
        if (filling && i_bit_valid && !i_start) begin
            bits <= {i_bit, bits[`PREAMBLE_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            filling  <= 1'b0;
            running  <= 1'b0;
            fill_cnt <= '0;
            o_done   <= 1'b0;
            o_offset <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                filling  <= 1'b1;
                running  <= 1'b0;
                fill_cnt <= '0;
            end else if (filling && i_bit_valid) begin
                fill_cnt <= fill_cnt + 1'b1;
                if (fill_cnt == FILL_W'(`PREAMBLE_BITS - 1)) begin
                    filling <= 1'b0;
                    running <= 1'b1;
                end
            end else if (running && window_done && last_offset) begin
                running  <= 1'b0;
                o_done   <= 1'b1;
                o_offset <= better ? offset : best_offset;
            end
        end
    end

    // one chip compared per cycle, then one cycle to rank the window
    always_ff @(posedge clk) begin
        if (rst || !running) begin
            offset      <= '0;
            sub         <= '0;
            score       <= '0;
            best_score  <= '0;
            best_offset <= '0;
        end else if (window_done) begin
            // strict compare keeps the earliest of equal scores
            if (better) begin
                best_score  <= score;
                best_offset <= offset;
            end
            offset <= offset + 1'b1;
            sub    <= '0;
            score  <= '0;
        end else begin
            if (bits[rd_idx] == pn_bit) begin
                score <= score + 1'b1;
            end
            sub <= sub + 1'b1;
        end
    end

    // scoring begins right on the bit that completes the preamble
    assert property (@(posedge clk) disable iff (rst)
        $rose(running) |-> $past(i_bit_valid) && fill_cnt == FILL_W'(`PREAMBLE_BITS))
        else $error("PN search started without a full preamble");

endmodule

`default_nettype wire

/* rtl/loopback_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mrr_settings.svh"

module loopback_ctrl (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_fm_flag,
    input  wire [7:0]                i_num_payload_bits,
    input  wire mrr_pkg::chip_cnt_t  i_wait_step,
    input  wire [`TX_BITS-1:0]       i_tx_word,
    input  wire                      i_tx_disable,
    input  wire                      i_bit_valid,
    input  wire                      i_bit,
    input  wire                      i_pn_done,
    input  wire mrr_pkg::pn_offset_t i_pn_offset,
    chip_if.ctrl                     chip,
    output logic                     o_timer_clear,
    output logic                     o_slicer_clear,
    output logic                     o_search_start,
    output logic                     o_busy,
    output logic                     o_pn_valid,
    output mrr_pkg::pn_offset_t      o_pn_offset,
    output logic                     o_payload_valid,
    output logic                     o_payload_bit,
    output logic                     o_tx_en,
    output logic                     o_tx_keep
);

    localparam int PRE_W = $clog2(`PREAMBLE_BITS + 1);
    localparam int TXC_W = $clog2(`TX_CHIPS_PER_BIT);
    localparam int TXB_W = $clog2(`TX_BITS);
    localparam mrr_pkg::chip_cnt_t TX_CHIPS = mrr_pkg::chip_cnt_t'(`TX_BITS * `TX_CHIPS_PER_BIT);
    localparam mrr_pkg::chip_cnt_t HOLD_CHIPS = mrr_pkg::chip_cnt_t'(`HOLDOFF_CHIPS);

    mrr_pkg::ctrl_state_t state;
    logic                 fm_q;
    logic                 start;
    logic                 pn_seen;
    logic                 pre_done;
    logic                 rx_done;
    logic                 tx_bit;
    logic                 tx_first_half;
    logic [PRE_W-1:0]     pre_cnt;
    logic [7:0]           payload_cnt;
    // shared by turnaround, transmit and holdoff
    mrr_pkg::chip_cnt_t   chip_cnt;
    mrr_pkg::chip_cnt_t   chip_cnt_next;

    assign start         = (state == mrr_pkg::READY) && fm_q;
    assign pre_done      = (pre_cnt == PRE_W'(`PREAMBLE_BITS));
    assign rx_done       = pre_done && (payload_cnt == i_num_payload_bits);
    assign chip_cnt_next = chip_cnt + mrr_pkg::chip_cnt_t'(chip.chip_end);

    // transmit chip count splits into bit index and chip within the bit
    assign tx_bit        = i_tx_word[chip_cnt[TXC_W +: TXB_W]];
    assign tx_first_half = (chip_cnt[TXC_W-1:0] < TXC_W'(`TX_CHIPS_PER_BIT / 2));

    assign o_timer_clear   = start;
    assign o_slicer_clear  = start;
    assign o_search_start  = (state == mrr_pkg::READY);
    assign o_busy          = (state != mrr_pkg::READY);
    assign o_pn_valid      = i_pn_done && (state == mrr_pkg::RX || state == mrr_pkg::RX_DRAIN);
    assign o_pn_offset     = i_pn_offset;
    assign o_payload_valid = (state == mrr_pkg::RX) && i_bit_valid && pre_done;
    assign o_payload_bit   = i_bit;
    assign o_tx_en = (state == mrr_pkg::TURNAROUND || state == mrr_pkg::TX) && !i_tx_disable;
    // a one keys the first half of its chips, a zero the second half
    assign o_tx_keep = (state == mrr_pkg::TX) && !i_tx_disable && (tx_bit == tx_first_half);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= mrr_pkg::READY;
            fm_q        <= 1'b0;
            pn_seen     <= 1'b0;
            pre_cnt     <= '0;
            payload_cnt <= '0;
            chip_cnt    <= '0;
        end else begin
            // frame detects outside READY are dropped
            fm_q <= i_fm_flag && (state == mrr_pkg::READY);
            if (i_pn_done) begin
                pn_seen <= 1'b1;
            end
            case (state)
                mrr_pkg::READY: begin
                    pn_seen     <= 1'b0;
                    pre_cnt     <= '0;
                    payload_cnt <= '0;
                    chip_cnt    <= '0;
                    if (fm_q) begin
                        state <= mrr_pkg::RX;
                    end
                end
                mrr_pkg::RX: begin
                    if (i_bit_valid && pre_done) begin
                        payload_cnt <= payload_cnt + 8'd1;
                    end else if (i_bit_valid) begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                    if (rx_done) begin
                        state <= (pn_seen || i_pn_done) ? mrr_pkg::TURNAROUND : mrr_pkg::RX_DRAIN;
                    end
                end
                mrr_pkg::RX_DRAIN: begin
                    if (i_pn_done) begin
                        state <= mrr_pkg::TURNAROUND;
                    end
                end
                mrr_pkg::TURNAROUND: begin
                    chip_cnt <= chip_cnt_next;
                    // >= so that a zero wait leaves at once
                    if (chip_cnt_next >= i_wait_step) begin
                        chip_cnt <= '0;
                        state    <= mrr_pkg::TX;
                    end
                end
                mrr_pkg::TX: begin
                    chip_cnt <= chip_cnt_next;
                    if (chip_cnt_next == TX_CHIPS) begin
                        chip_cnt <= '0;
                        state    <= mrr_pkg::HOLDOFF;
                    end
                end
                mrr_pkg::HOLDOFF: begin
                    chip_cnt <= chip_cnt_next;
                    if (chip_cnt_next == HOLD_CHIPS) begin
                        state <= mrr_pkg::READY;
                    end
                end
                default: state <= mrr_pkg::READY;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) o_tx_keep |-> o_tx_en)
        else $error("tx_keep raised while tx_en is low");

endmodule

`default_nettype wire

/* rtl/mrr_loopback_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mrr_settings.svh"

module mrr_loopback_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      i_sample_valid,
    input  wire mrr_pkg::sample_t    i_sample,
    input  wire                      i_fm_flag,
    input  wire [7:0]                i_num_payload_bits,
    input  wire mrr_pkg::chip_cnt_t  i_wait_step,
    input  wire [`TX_BITS-1:0]       i_tx_word,
    input  wire                      i_tx_disable,
    output logic                     o_busy,
    output logic                     o_pn_valid,
    output mrr_pkg::pn_offset_t      o_pn_offset,
    output logic                     o_payload_valid,
    output logic                     o_payload_bit,
    output logic                     o_tx_en,
    output logic                     o_tx_keep
);

    logic                timer_clear;
    logic                slicer_clear;
    logic                search_start;
    logic                bit_valid;
    logic                bit_value;
    logic                pn_done;
    mrr_pkg::pn_offset_t pn_offset;

    chip_if u_chip ();

    chip_timer u_chip_timer (
        .clk            (clk),
        .rst            (rst),
        .i_clear        (timer_clear),
        .i_sample_valid (i_sample_valid),
        .i_sample       (i_sample),
        .chip           (u_chip)
    );

    bit_slicer u_bit_slicer (
        .clk         (clk),
        .rst         (rst),
        .i_clear     (slicer_clear),
        .chip        (u_chip),
        .o_bit_valid (bit_valid),
        .o_bit       (bit_value)
    );

    pn_search u_pn_search (
        .clk         (clk),
        .rst         (rst),
        .i_start     (search_start),
        .i_bit_valid (bit_valid),
        .i_bit       (bit_value),
        .o_done      (pn_done),
        .o_offset    (pn_offset)
    );

    loopback_ctrl u_loopback_ctrl (
        .clk                (clk),
        .rst                (rst),
        .i_fm_flag          (i_fm_flag),
        .i_num_payload_bits (i_num_payload_bits),
        .i_wait_step        (i_wait_step),
        .i_tx_word          (i_tx_word),
        .i_tx_disable       (i_tx_disable),
        .i_bit_valid        (bit_valid),
        .i_bit              (bit_value),
        .i_pn_done          (pn_done),
        .i_pn_offset        (pn_offset),
        .chip               (u_chip),
        .o_timer_clear      (timer_clear),
        .o_slicer_clear     (slicer_clear),
        .o_search_start     (search_start),
        .o_busy             (o_busy),
        .o_pn_valid         (o_pn_valid),
        .o_pn_offset        (o_pn_offset),
        .o_payload_valid    (o_payload_valid),
        .o_payload_bit      (o_payload_bit),
        .o_tx_en            (o_tx_en),
        .o_tx_keep          (o_tx_keep)
    );

endmodule

`default_nettype wire

/* dv/tb_mrr_loopback.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mrr_settings.svh"

module tb_mrr_loopback;

    localparam int NUM_PAYLOAD = 6;
    localparam logic [`PN_LEN-1:0] PN = `PN_SEQ;

    logic                clk;
    logic                rst;
    logic                i_sample_valid;
    mrr_pkg::sample_t    i_sample;
    logic                i_fm_flag;
    logic [7:0]          i_num_payload_bits;
    mrr_pkg::chip_cnt_t  i_wait_step;
    logic [`TX_BITS-1:0] i_tx_word;
    logic                i_tx_disable;
    logic                o_busy;
    logic                o_pn_valid;
    mrr_pkg::pn_offset_t o_pn_offset;
    logic                o_payload_valid;
    logic                o_payload_bit;
    logic                o_tx_en;
    logic                o_tx_keep;

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lcg_state;
    logic        frame_started;
    int          exp_offset;
    logic        exp_payload[$];

    // monitor counters, cleared when busy rises
    logic busy_q;
    int   smp_idx;
    int   tx_chips;
    int   hold_chips;
    logic tx_seen;
    int   pay_cnt;
    int   pn_cnt;

    mrr_loopback_top u_dut (
        .clk                (clk),
        .rst                (rst),
        .i_sample_valid     (i_sample_valid),
        .i_sample           (i_sample),
        .i_fm_flag          (i_fm_flag),
        .i_num_payload_bits (i_num_payload_bits),
        .i_wait_step        (i_wait_step),
        .i_tx_word          (i_tx_word),
        .i_tx_disable       (i_tx_disable),
        .o_busy             (o_busy),
        .o_pn_valid         (o_pn_valid),
        .o_pn_offset        (o_pn_offset),
        .o_payload_valid    (o_payload_valid),
        .o_payload_bit      (o_payload_bit),
        .o_tx_en            (o_tx_en),
        .o_tx_keep          (o_tx_keep)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    // first offset with the strictly highest count of chips equal to the PN
    function automatic int best_offset(input logic pre[`PREAMBLE_BITS]);
        int best;
        int best_score;
        int score;
        best = 0;
        best_score = -1;
        for (int k = 0; k < `SEARCH_OFFSETS; k++) begin
            score = 0;
            for (int j = 0; j < `PN_LEN; j++) begin
                if (pre[k + j] == PN[`PN_LEN - 1 - j]) begin
                    score++;
                end
            end
            if (score > best_score) begin
                best_score = score;
                best = k;
            end
        end
        return best;
    endfunction

    // roughly one strobe in four is dropped
    task automatic drive_sample(input mrr_pkg::sample_t v);
        while (lcg_next() % 4 == 0) begin
            i_sample_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        i_sample_valid = 1'b1;
        i_sample = v;
        @(posedge clk);
        #1;
        i_sample_valid = 1'b0;
    endtask

    task automatic drive_bit(input logic b);
        logic high;
        for (int c = 0; c < `CHIPS_PER_BIT; c++) begin
            high = b ? (c == 5 || c == 6) : (c == 3 || c == 4);
            for (int s = 0; s < `SAMPLES_PER_CHIP; s++) begin
                drive_sample(high ? 12'd2800 + 12'(lcg_next() % 256) : 12'(lcg_next() % 128));
            end
        end
    endtask

    task automatic run_frame(input string name, input int pn_pos, input int wait_chips,
                             input logic disable_tx, input logic retrigger);
        int   errs_before;
        int   guard;
        logic pre[`PREAMBLE_BITS];
        errs_before = errors;
        for (int i = 0; i < `PREAMBLE_BITS; i++) begin
            pre[i] = 1'(lcg_next() % 2);
        end
        for (int j = 0; j < `PN_LEN; j++) begin
            pre[pn_pos + j] = PN[`PN_LEN - 1 - j];
        end
        exp_offset = best_offset(pre);
        exp_payload.delete();
        for (int i = 0; i < NUM_PAYLOAD; i++) begin
            exp_payload.push_back(1'(lcg_next() % 2));
        end
        i_num_payload_bits = 8'(NUM_PAYLOAD);
        i_wait_step = 16'(wait_chips);
        i_tx_word = lcg_next();
        i_tx_disable = disable_tx;
        frame_started = 1'b1;
        i_fm_flag = 1'b1;
        @(posedge clk);
        #1;
        i_fm_flag = 1'b0;
        guard = 0;
        while (!o_busy && guard < 20) begin
            @(posedge clk);
            #1;
            guard++;
        end
        if (!o_busy) begin
            $display("frame %s: busy never rose after the frame detect", name);
            errors++;
        end
        for (int i = 0; i < `PREAMBLE_BITS; i++) begin
            drive_bit(pre[i]);
        end
        foreach (exp_payload[i]) begin
            drive_bit(exp_payload[i]);
        end
        // keep the chip clock running through turnaround, transmit and holdoff
        guard = 0;
        while (o_busy && guard < 4000) begin
            // frame detect held up to the last busy cycle
            i_fm_flag = retrigger;
            drive_sample(12'(lcg_next() % 128));
            i_fm_flag = 1'b0;
            guard++;
        end
        if (o_busy) begin
            $display("frame %s: timed out waiting for busy to drop", name);
            errors++;
        end
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            assert (!o_busy) else begin
                $display("frame %s: a new frame started after the frame detect", name);
                errors++;
            end
        end
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    always @(negedge clk) begin
        int c;
        logic exp_keep;
        if (o_busy && !busy_q) begin
            smp_idx = 0;
            tx_chips = 0;
            hold_chips = 0;
            tx_seen = 1'b0;
            pay_cnt = 0;
            pn_cnt = 0;
        end
        if (o_payload_valid) begin
            assert (pay_cnt < exp_payload.size() && o_payload_bit == exp_payload[pay_cnt])
                else report_mismatch("o_payload_bit", int'(o_payload_bit),
                                     pay_cnt < exp_payload.size() ?
                                     int'(exp_payload[pay_cnt]) : 0);
            pay_cnt++;
        end
        if (o_pn_valid) begin
            assert (int'(o_pn_offset) == exp_offset)
                else report_mismatch("o_pn_offset", int'(o_pn_offset), exp_offset);
            pn_cnt++;
        end
        if (o_tx_en) begin
            tx_seen = 1'b1;
            c = tx_chips - int'(i_wait_step);
            // LSB first, a one keys the first two of its four chips
            if (c < 0) begin
                exp_keep = 1'b0;
            end else begin
                exp_keep = i_tx_word[c / 4] ? (c % 4 < 2) : (c % 4 >= 2);
            end
            assert (o_tx_keep == exp_keep) else report_mismatch("o_tx_keep", int'(o_tx_keep),
                                                                int'(exp_keep));
        end
        if (i_sample_valid && o_busy) begin
            if (smp_idx % `SAMPLES_PER_CHIP == `SAMPLES_PER_CHIP - 1) begin
                if (o_tx_en) begin
                    tx_chips++;
                end else if (tx_seen) begin
                    hold_chips++;
                end
            end
            smp_idx++;
        end
        if (!o_busy && busy_q) begin
            assert (pay_cnt == int'(i_num_payload_bits))
                else report_mismatch("payload count", pay_cnt, int'(i_num_payload_bits));
            assert (pn_cnt == 1) else report_mismatch("o_pn_valid count", pn_cnt, 1);
            if (i_tx_disable) begin
                assert (!tx_seen) else report_mismatch("o_tx_en", 1, 0);
            end else begin
                assert (tx_chips == int'(i_wait_step) + `TX_BITS * `TX_CHIPS_PER_BIT)
                    else report_mismatch("tx_en chips", tx_chips,
                                         int'(i_wait_step) + `TX_BITS * `TX_CHIPS_PER_BIT);
                assert (hold_chips == `HOLDOFF_CHIPS)
                    else report_mismatch("holdoff chips", hold_chips, `HOLDOFF_CHIPS);
            end
        end
        busy_q = o_busy;
    end

    assert property (@(posedge clk) disable iff (rst)
        !frame_started |-> !(o_busy || o_tx_en || o_tx_keep || o_pn_valid || o_payload_valid))
        else begin
            $display("outputs not idle before the first frame at %0t ns", $time);
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst) o_tx_keep |-> o_tx_en)
        else begin
            $display("o_tx_keep high while o_tx_en low at %0t ns", $time);
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst) i_tx_disable |-> !o_tx_en && !o_tx_keep)
        else begin
            $display("transmit active while disabled at %0t ns", $time);
            errors++;
        end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        i_sample_valid = 1'b0;
        i_sample = '0;
        i_fm_flag = 1'b0;
        i_num_payload_bits = '0;
        i_wait_step = '0;
        i_tx_word = '0;
        i_tx_disable = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        lcg_state = 32'h6ec201fa;
        frame_started = 1'b0;
        exp_offset = 0;
        busy_q = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (30) @(posedge clk);
        #1;
        tests_run++;
        if (errors == 0) begin
            $display("test idle_after_reset: pass");
        end else begin
            tests_failed++;
            $display("test idle_after_reset: fail");
        end
        run_frame("pn_offset_0", 0, 5, 1'b0, 1'b0);
        run_frame("pn_offset_15_retrigger", 15, 3, 1'b0, 1'b1);
        run_frame("tx_disabled", int'(lcg_next() % 16), 2, 1'b1, 1'b0);
        run_frame("random_offset", int'(lcg_next() % 16), 9, 1'b0, 1'b0);
        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+rtl
rtl/mrr_pkg.sv
rtl/chip_if.sv
rtl/chip_timer.sv
rtl/bit_slicer.sv
rtl/pn_search.sv
rtl/loopback_ctrl.sv
rtl/mrr_loopback_top.sv
dv/tb_mrr_loopback.sv

/* Makefile */
TOP := tb_mrr_loopback

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
